/* list.f */
tt_cfg_pkg.sv
tt_bus_pkg.sv
tt_apb_regs.sv
tt_prescaler.sv
tt_counter.sv
tt_match_irq.sv
tick_timer_top.sv
tb_tick_timer.sv

/* tb_tick_timer.sv */
//////////////////////////////////////////////////
// Self-checking testbench for the tick timer.
// Runs a table of APB register operations and
// interrupt waits against the top level and
// reports the error counts at the end.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_tick_timer;

   import tt_cfg_pkg::*;
   import tt_bus_pkg::*;

   typedef enum logic [2:0] {
      OP_WR,     // APB write, check pslverr
      OP_RD,     // Read, data must equal exp
      OP_RD_LE,  // Read, data at most exp
      OP_RD_GT,  // Read, data above exp
      OP_IRQ,    // Wait until irq_o equals exp[0]
      OP_HOLD    // irq_o must stay at exp[0]
   } op_e;

   typedef struct packed {
      op_e         op;
      logic [11:0] addr;
      logic [31:0] data;   // Write data, or earliest cycle for OP_IRQ
      logic [31:0] exp;    // Expected read data or irq level
      logic        err;    // Expected pslverr
      logic [15:0] bound;  // Cycle limit of a wait
   } entry_t;

   localparam int P = 5;  // Period in the timing tests
   localparam int N = 3;  // Prescaler in the timing tests
   localparam int IRQ_CYC = P * (N + 1) + 1;  // Cycles from TTMR write to irq_o
   localparam logic [31:0] PRESC_MASK = (32'd1 << DEF_PRESC_W) - 32'd1;
   localparam logic [31:0] CNT_MASK   = (32'd1 << DEF_CNT_W) - 32'd1;
   localparam logic [11:0] ADDR_BAD   = 12'h010;  // Outside the register map

   logic        clk;
   logic        rst;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   logic        irq_o;

   entry_t      tbl [0:63];
   entry_t      cur;
   int          n_ent;
   int          k;
   int          val_errs;
   int          to_errs;
   integer      seed;
   logic [31:0] rdata;
   logic        rerr;
   logic [31:0] r_presc;  // Random patterns
   logic [31:0] r_ttmr;
   logic [31:0] r_cnt;
   logic [31:0] r_bad;
   logic [31:0] ttmr_w;

   tick_timer_top i_dut (
      .clk       (clk),
      .rst       (rst),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp),
      .irq_o     (irq_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   // TTMR layout: mode, ie, ip (read only), period
   function automatic logic [31:0] ttmr_val(input tt_mode_e mode, input logic ie,
                                            input int period);
      ttmr_val = {mode, ie, 1'b0, 28'(period)};
   endfunction

   task automatic add(input op_e op, input logic [11:0] addr, input logic [31:0] data,
                      input logic [31:0] exp, input logic err, input int bound);
      tbl[n_ent] = '{op, addr, data, exp, err, 16'(bound)};
      n_ent++;
   endtask

   // Setup and access phase, both driven on falling edges
   task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rd, output logic slverr);
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clk);
      apb_req.penable = 1'b1;  // Access, commits at next rising edge
      #1;  // Response sampled inside the access phase
      if (apb_rsp.pready !== 1'b1)
      begin
         $display("error at %0t ns: pready low in access to 0x%03h", $time, addr);
         val_errs++;
      end
      rd     = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(negedge clk);
      apb_req = '0;  // Back to idle
   endtask

   task automatic wait_irq(input logic lvl, input int min_cyc, input int max_cyc);
      int n;
      n = 0;
      while (irq_o !== lvl && n < max_cyc)
      begin
         @(negedge clk);
         n++;
      end
      if (irq_o !== lvl)
      begin
         $display("timeout: irq_o did not go to %b within %0d cycles", lvl, max_cyc);
         to_errs++;
      end
      else if (n < min_cyc)
      begin
         $display("error at %0t ns: irq_o went to %b after %0d cycles, expected at least %0d",
                  $time, lvl, n, min_cyc);
         val_errs++;
      end
   endtask

   task automatic hold_irq(input logic lvl, input int cycles);
      int  i;
      logic bad;
      bad = 1'b0;
      for (i = 0; i < cycles; i++)
      begin
         @(negedge clk);
         if (!bad && irq_o !== lvl)  // Report only the first slip
         begin
            $display("error at %0t ns: irq_o is %b, expected to hold %b", $time, irq_o, lvl);
            val_errs++;
            bad = 1'b1;
         end
      end
   endtask

   initial
   begin
      rst      = 1'b1;
      apb_req  = '0;
      n_ent    = 0;
      val_errs = 0;
      to_errs  = 0;
      seed     = 44423;
      r_presc  = $random(seed);
      r_ttmr   = $random(seed);
      r_cnt    = $random(seed);
      r_bad    = $random(seed);
      ttmr_w   = (r_ttmr & 32'h0FFF_FFFF) | 32'h3000_0000;  // Mode off, ie on, bit 28 forced
      r_cnt    = {r_cnt[31:28], ttmr_w[27:0]};  // Count on the period, silent while disabled

      // Readback, masking, unmapped offset
      add(OP_WR, ADDR_PRESC, r_presc, 0, 1'b0, 0);
      add(OP_RD, ADDR_PRESC, 0, r_presc & PRESC_MASK, 1'b0, 0);
      add(OP_WR, ADDR_TTMR, ttmr_w, 0, 1'b0, 0);
      add(OP_RD, ADDR_TTMR, 0, {ttmr_w[31:29], 1'b0, ttmr_w[27:0] & CNT_MASK[27:0]}, 1'b0, 0);
      add(OP_WR, ADDR_BAD, r_bad, 0, 1'b1, 0);
      add(OP_RD, ADDR_BAD, 0, 0, 1'b1, 0);
      add(OP_RD, ADDR_PRESC, 0, r_presc & PRESC_MASK, 1'b0, 0);  // Bad write ignored
      // Disabled mode keeps the count
      add(OP_WR, ADDR_TTCR, r_cnt, 0, 1'b0, 0);
      add(OP_HOLD, 0, 0, 0, 1'b0, 60);
      add(OP_RD, ADDR_TTCR, 0, r_cnt, 1'b0, 0);
      add(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0);
      // Stop mode
      add(OP_WR, ADDR_TTMR, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_TTCR, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_PRESC, N, 0, 1'b0, 0);
      add(OP_WR, ADDR_TTMR, ttmr_val(STOP, 1'b1, P), 0, 1'b0, 0);
      add(OP_IRQ, 0, IRQ_CYC - 2, 1, 1'b0, IRQ_CYC + 2);
      add(OP_RD, ADDR_TTCR, 0, P, 1'b0, 0);
      add(OP_HOLD, 0, 0, 1, 1'b0, 25);
      add(OP_RD, ADDR_TTCR, 0, P, 1'b0, 0);  // Still frozen
      add(OP_RD, ADDR_STATUS, 0, 1, 1'b0, 0);
      // W1C of ip
      add(OP_WR, ADDR_STATUS, 1, 0, 1'b0, 0);
      add(OP_IRQ, 0, 0, 0, 1'b0, 4);
      add(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0);
      // Restart mode, second match gives overrun
      add(OP_WR, ADDR_TTMR, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_TTCR, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_TTMR, ttmr_val(RESTART, 1'b1, P), 0, 1'b0, 0);
      add(OP_IRQ, 0, IRQ_CYC - 2, 1, 1'b0, IRQ_CYC + 2);
      add(OP_RD_LE, ADDR_TTCR, 0, P, 1'b0, 0);
      add(OP_HOLD, 0, 0, 1, 1'b0, 10);
      add(OP_RD_LE, ADDR_TTCR, 0, P, 1'b0, 0);
      add(OP_HOLD, 0, 0, 1, 1'b0, 10);
      add(OP_RD_LE, ADDR_TTCR, 0, P, 1'b0, 0);
      add(OP_HOLD, 0, 0, 1, 1'b0, 15);  // Past one full restart cycle
      add(OP_RD, ADDR_STATUS, 0, 3, 1'b0, 0);
      // Continuous mode runs past the period
      add(OP_WR, ADDR_TTMR, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_TTCR, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_STATUS, 3, 0, 1'b0, 0);
      add(OP_RD, ADDR_STATUS, 0, 0, 1'b0, 0);
      add(OP_WR, ADDR_TTMR, ttmr_val(CONTINUOUS, 1'b1, P), 0, 1'b0, 0);
      add(OP_IRQ, 0, IRQ_CYC - 2, 1, 1'b0, IRQ_CYC + 2);
      add(OP_HOLD, 0, 0, 1, 1'b0, 20);
      add(OP_RD_GT, ADDR_TTCR, 0, P, 1'b0, 0);

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      if (irq_o !== 1'b0 || apb_rsp !== '0)  // Quiet after reset
      begin
         $display("error at %0t ns: outputs not zero after reset", $time);
         val_errs++;
      end

      for (k = 0; k < n_ent; k++)
      begin
         cur = tbl[k];
         case (cur.op)
            OP_IRQ:  wait_irq(cur.exp[0], cur.data, cur.bound);
            OP_HOLD: hold_irq(cur.exp[0], cur.bound);
            default:
            begin
               apb_xfer(cur.op == OP_WR, cur.addr, cur.data, rdata, rerr);
               if (rerr !== cur.err)
               begin
                  $display("error at %0t ns: entry %0d pslverr %b, expected %b",
                           $time, k, rerr, cur.err);
                  val_errs++;
               end
               if (cur.op == OP_RD && rdata !== cur.exp)
               begin
                  $display("error at %0t ns: entry %0d read 0x%03h gave 0x%08h, expected 0x%08h",
                           $time, k, cur.addr, rdata, cur.exp);
                  val_errs++;
               end
               if (cur.op == OP_RD_LE && !(rdata <= cur.exp))  // Restart never passes P
               begin
                  $display("error at %0t ns: entry %0d read 0x%08h, expected at most 0x%08h",
                           $time, k, rdata, cur.exp);
                  val_errs++;
               end
               if (cur.op == OP_RD_GT && !(rdata > cur.exp))
               begin
                  $display("error at %0t ns: entry %0d read 0x%08h, expected above 0x%08h",
                           $time, k, rdata, cur.exp);
                  val_errs++;
               end
            end
         endcase
      end

      $display("checks done: %0d value errors, %0d timeouts", val_errs, to_errs);
      if (val_errs == 0 && to_errs == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

/* tick_timer_top.sv */
//////////////////////////////////////////////////
// Tick timer top level. APB slave port in, one
// level interrupt out. CNT_W (at most 28) and
// PRESC_W (at most 8) size the compare and the
// divider and are passed to the blocks below.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tick_timer_top #(
   parameter int unsigned CNT_W   = tt_cfg_pkg::DEF_CNT_W,
   parameter int unsigned PRESC_W = tt_cfg_pkg::DEF_PRESC_W
) (
   input  logic                 clk,
   input  logic                 rst,
   input  tt_bus_pkg::apb_req_t apb_req_i,
   output tt_bus_pkg::apb_rsp_t apb_rsp_o,
   output logic                 irq_o
);

   import tt_cfg_pkg::*;

   tt_ctrl_t    ctrl;        // Live register values
   logic        presc_load;  // Divider restart
   logic        cnt_load;    // TTCR write strobe
   logic [31:0] cnt_wdata;   // TTCR write data
   logic        tick;        // Prescaled enable
   logic [31:0] count;       // TTCR value
   logic        match;       // Counter equals period
   logic        ip;          // Pending flag
   logic        ovr;         // Overrun flag
   logic        ip_clr;      // W1C strobes
   logic        ovr_clr;

   tt_apb_regs #(
      .CNT_W   (CNT_W),
      .PRESC_W (PRESC_W)
   ) i_regs (
      .clk          (clk),
      .rst          (rst),
      .apb_req_i    (apb_req_i),
      .apb_rsp_o    (apb_rsp_o),
      .ctrl_o       (ctrl),
      .presc_load_o (presc_load),
      .cnt_load_o   (cnt_load),
      .cnt_wdata_o  (cnt_wdata),
      .count_i      (count),
      .ip_i         (ip),
      .ovr_i        (ovr),
      .ip_clr_o     (ip_clr),
      .ovr_clr_o    (ovr_clr)
   );

   tt_prescaler #(
      .PRESC_W (PRESC_W)
   ) i_presc (
      .clk    (clk),
      .rst    (rst),
      .ctrl_i (ctrl),
      .load_i (presc_load),
      .tick_o (tick)
   );

   tt_counter i_cnt (
      .clk         (clk),
      .rst         (rst),
      .ctrl_i      (ctrl),
      .tick_i      (tick),
      .match_i     (match),
      .load_i      (cnt_load),
      .load_data_i (cnt_wdata),
      .count_o     (count)
   );

   tt_match_irq #(
      .CNT_W (CNT_W)
   ) i_match (
      .clk       (clk),
      .rst       (rst),
      .ctrl_i    (ctrl),
      .count_i   (count),
      .ip_clr_i  (ip_clr),
      .ovr_clr_i (ovr_clr),
      .match_o   (match),
      .ip_o      (ip),
      .ovr_o     (ovr),
      .irq_o     (irq_o)
   );

endmodule

/* tt_match_irq.sv */
//////////////////////////////////////////////////
// Match and interrupt logic of the tick timer.
// Compares the low CNT_W counter bits with the
// period, turns the match rising edge into a
// sticky pending flag and flags overruns.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tt_match_irq #(
   parameter int unsigned CNT_W = tt_cfg_pkg::DEF_CNT_W
) (
   input  logic                 clk,
   input  logic                 rst,
   input  tt_cfg_pkg::tt_ctrl_t ctrl_i,
   input  logic [31:0]          count_i,
   input  logic                 ip_clr_i,
   input  logic                 ovr_clr_i,
   output logic                 match_o,
   output logic                 ip_o,
   output logic                 ovr_o,
   output logic                 irq_o
);

   import tt_cfg_pkg::*;

   logic match;    // Compare result
   logic match_q;  // Previous cycle, for edge detect
   logic hit;      // New match with interrupts on
   logic ip_q;     // Interrupt pending
   logic ovr_q;    // Match while already pending

   // Skipped when disabled so a zero count after reset is silent
   assign match = (ctrl_i.mode != DISABLED) &&
                  (count_i[CNT_W-1:0] == ctrl_i.period[CNT_W-1:0]);

   assign hit = match && !match_q && ctrl_i.ie;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         match_q <= 1'b0;
         ip_q    <= 1'b0;
         ovr_q   <= 1'b0;
      end
      else
      begin
         match_q <= match;
         if (hit)
            ip_q <= 1'b1;  // Set beats clear
         else if (ip_clr_i)
            ip_q <= 1'b0;
         if (hit && ip_q)
            ovr_q <= 1'b1;  // Previous one never serviced
         else if (ovr_clr_i)
            ovr_q <= 1'b0;
      end
   end

   assign match_o = match;
   assign ip_o    = ip_q;
   assign ovr_o   = ovr_q;
   assign irq_o   = ip_q;

   // Overrun needs an interrupt that was pending the cycle before
   a_ovr_needs_ip: assert property (@(posedge clk) disable iff (rst)
      $rose(ovr_o) |-> $past(ip_o));

endmodule

/* tt_counter.sv */
//////////////////////////////////////////////////
// 32-bit tick counter (TTCR). Advances on each
// prescaled tick, takes software loads, and on a
// match clears, holds or keeps counting according
// to the timer mode.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tt_counter (
   input  logic                 clk,
   input  logic                 rst,
   input  tt_cfg_pkg::tt_ctrl_t ctrl_i,
   input  logic                 tick_i,
   input  logic                 match_i,
   input  logic                 load_i,
   input  logic [31:0]          load_data_i,
   output logic [31:0]          count_o
);

   import tt_cfg_pkg::*;

   logic [31:0] count_q;  // TTCR value

   always_ff @(posedge clk)
   begin
      if (rst)
         count_q <= '0;
      else if (load_i)
         count_q <= load_data_i;  // Software write wins over a tick
      else if (tick_i)
      begin
         if (match_i)
         begin
            case (ctrl_i.mode)
               RESTART:    count_q <= '0;
               CONTINUOUS: count_q <= count_q + 32'd1;  // Wraps at 2^32
               STOP:       count_q <= count_q;          // Frozen at the period
               default:    count_q <= count_q;          // No ticks when disabled
            endcase
         end
         else
         begin
            count_q <= count_q + 32'd1;
         end
      end
   end

   assign count_o = count_q;

endmodule

/* tt_prescaler.sv */
//////////////////////////////////////////////////
// Programmable divider for the tick timer. Emits
// a one-cycle tick every presc+1 clocks while the
// timer is enabled; load_i restarts the phase.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tt_prescaler #(
   parameter int unsigned PRESC_W = tt_cfg_pkg::DEF_PRESC_W
) (
   input  logic                 clk,
   input  logic                 rst,
   input  tt_cfg_pkg::tt_ctrl_t ctrl_i,
   input  logic                 load_i,
   output logic                 tick_o
);

   import tt_cfg_pkg::*;

   logic [PRESC_W-1:0] reload;  // Implemented prescaler bits
   logic [PRESC_W-1:0] cnt_q;   // Clocks left until the next tick
   logic               run;     // Timer enabled

   assign reload = ctrl_i.presc[PRESC_W-1:0];
   assign run    = (ctrl_i.mode != DISABLED);

   // Down-counter, sits at the reload value while stopped
   always_ff @(posedge clk)
   begin
      if (rst)
         cnt_q <= '0;
      else if (!run || load_i)
         cnt_q <= reload;  // Restart phase
      else if (cnt_q == '0)
         cnt_q <= reload;  // Tick now, next one in presc+1
      else
         cnt_q <= cnt_q - 1'b1;
   end

   // Load cycle is quiet so the first tick lands presc+1 clocks later
   assign tick_o = run && !load_i && (cnt_q == '0);

   // Counter never advances in disabled mode
   a_no_tick_disabled: assert property (@(posedge clk) disable iff (rst)
      ctrl_i.mode == DISABLED |-> !tick_o);

endmodule

/* tt_apb_regs.sv */
//////////////////////////////////////////////////
// APB register block of the tick timer. Decodes
// the bus, holds TTMR and PRESC, captures read
// data at the start of the access phase and
// issues one-cycle load and clear strobes to the
// datapath after each committed write.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tt_apb_regs #(
   parameter int unsigned CNT_W   = tt_cfg_pkg::DEF_CNT_W,
   parameter int unsigned PRESC_W = tt_cfg_pkg::DEF_PRESC_W
) (
   input  logic                 clk,
   input  logic                 rst,
   input  tt_bus_pkg::apb_req_t apb_req_i,
   output tt_bus_pkg::apb_rsp_t apb_rsp_o,
   output tt_cfg_pkg::tt_ctrl_t ctrl_o,
   output logic                 presc_load_o,
   output logic                 cnt_load_o,
   output logic [31:0]          cnt_wdata_o,
   input  logic [31:0]          count_i,
   input  logic                 ip_i,
   input  logic                 ovr_i,
   output logic                 ip_clr_o,
   output logic                 ovr_clr_o
);

   import tt_cfg_pkg::*;
   import tt_bus_pkg::*;

   // Keep only the implemented bits of each field
   localparam logic [PERIOD_W-1:0] PERIOD_MASK = PERIOD_W'((64'd1 << CNT_W) - 64'd1);
   localparam logic [PRESC_FW-1:0] PRESC_MASK  = PRESC_FW'((64'd1 << PRESC_W) - 64'd1);

   apb_phase_e  phase_d;       // Phase on the bus this cycle
   apb_phase_e  phase_q;       // Phase one cycle ago
   logic        addr_hit;      // Offset maps to a register
   logic        access_ok;     // Access directly after setup
   logic        wr_en;         // Write commits at this edge
   logic [31:0] rdata_d;       // Read mux
   logic [31:0] rdata_q;       // Held for the access phase
   tt_ctrl_t    ctrl_q;        // Mode, ie, period, prescaler
   logic        presc_load_q;  // Divider restart
   logic        cnt_load_q;    // TTCR load strobe
   logic [31:0] cnt_wdata_q;   // TTCR load value
   logic        ip_clr_q;      // W1C to STATUS[0]
   logic        ovr_clr_q;     // W1C to STATUS[1]

   always_comb
   begin
      if (!apb_req_i.psel)
         phase_d = IDLE;
      else if (!apb_req_i.penable)
         phase_d = SETUP;
      else
         phase_d = ACCESS;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         phase_q <= IDLE;
      else
         phase_q <= phase_d;
   end

   // Offset decode and read mux
   always_comb
   begin
      addr_hit = 1'b1;
      rdata_d  = '0;  // Unmapped reads as zero
      case (apb_req_i.paddr)
         ADDR_TTMR:   rdata_d = {ctrl_q.mode, ctrl_q.ie, ip_i, ctrl_q.period};
         ADDR_TTCR:   rdata_d = count_i;
         ADDR_PRESC:  rdata_d = {24'h0, ctrl_q.presc};
         ADDR_STATUS: rdata_d = {30'h0, ovr_i, ip_i};
         default:     addr_hit = 1'b0;
      endcase
   end

   assign access_ok = (phase_d == ACCESS) && (phase_q == SETUP);
   assign wr_en     = access_ok && apb_req_i.pwrite && addr_hit;

   // Sample at the setup edge so the access phase sees a stable value
   always_ff @(posedge clk)
   begin
      if (rst)
         rdata_q <= '0;
      else if (phase_d == SETUP)
         rdata_q <= rdata_d;
   end

   // Register writes and datapath strobes
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl_q       <= '0;  // DISABLED, ie off
         presc_load_q <= 1'b0;
         cnt_load_q   <= 1'b0;
         cnt_wdata_q  <= '0;
         ip_clr_q     <= 1'b0;
         ovr_clr_q    <= 1'b0;
      end
      else
      begin
         presc_load_q <= 1'b0;  // Strobes last one cycle
         cnt_load_q   <= 1'b0;
         ip_clr_q     <= 1'b0;
         ovr_clr_q    <= 1'b0;
         if (wr_en)
         begin
            case (apb_req_i.paddr)
               ADDR_TTMR:
               begin
                  ctrl_q.mode   <= tt_mode_e'(apb_req_i.pwdata[31:30]);
                  ctrl_q.ie     <= apb_req_i.pwdata[29];
                  ctrl_q.period <= apb_req_i.pwdata[PERIOD_W-1:0] & PERIOD_MASK;  // Bit 28 is ip
                  presc_load_q  <= 1'b1;  // Realign divider to the new mode
               end
               ADDR_TTCR:
               begin
                  cnt_load_q  <= 1'b1;
                  cnt_wdata_q <= apb_req_i.pwdata;
               end
               ADDR_PRESC:
               begin
                  ctrl_q.presc <= apb_req_i.pwdata[PRESC_FW-1:0] & PRESC_MASK;
                  presc_load_q <= 1'b1;
               end
               ADDR_STATUS:
               begin
                  ip_clr_q  <= apb_req_i.pwdata[0];
                  ovr_clr_q <= apb_req_i.pwdata[1];
               end
               default: ;
            endcase
         end
      end
   end

   assign apb_rsp_o.pready  = (phase_q == SETUP);  // High in the access that follows
   assign apb_rsp_o.prdata  = rdata_q;
   assign apb_rsp_o.pslverr = (phase_q == SETUP) && !addr_hit;

   assign ctrl_o       = ctrl_q;
   assign presc_load_o = presc_load_q;
   assign cnt_load_o   = cnt_load_q;
   assign cnt_wdata_o  = cnt_wdata_q;
   assign ip_clr_o     = ip_clr_q;
   assign ovr_clr_o    = ovr_clr_q;

   // Every access phase is entered straight from a setup phase
   a_access_after_setup: assert property (@(posedge clk) disable iff (rst)
      phase_d == ACCESS |-> phase_q == SETUP);

   // Offset held by the master from setup into access
   a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
      phase_d == ACCESS |-> $stable(apb_req_i.paddr));

   // Ready only when the master is really in its access phase
   a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
      apb_rsp_o.pready |-> phase_d == ACCESS);

endmodule

/* tt_bus_pkg.sv */
//////////////////////////////////////////////////
// APB bus types for the timer slave port: request
// and response bundles plus the phase encoding
// used by the register block.
//////////////////////////////////////////////////

package tt_bus_pkg;

   // Master to slave
   typedef struct packed {
      logic        psel;     // Slave selected
      logic        penable;  // Access phase marker
      logic        pwrite;   // 1 for write
      logic [11:0] paddr;    // Byte offset
      logic [31:0] pwdata;   // Write data
   } apb_req_t;

   // Slave to master
   typedef struct packed {
      logic        pready;   // Always 1 in access, no wait states
      logic [31:0] prdata;   // Read data
      logic        pslverr;  // Unmapped offset
   } apb_rsp_t;

   // Transfer phase
   typedef enum logic [1:0] {
      IDLE   = 2'd0,  // No transfer
      SETUP  = 2'd1,  // psel without penable
      ACCESS = 2'd2   // psel and penable
   } apb_phase_e;

endpackage

/* tt_cfg_pkg.sv */
//////////////////////////////////////////////////
// Tick timer configuration definitions: register
// offsets, timer mode encoding and the control
// bundle that the register block hands to the
// datapath. Modules take it by wildcard import.
//////////////////////////////////////////////////

package tt_cfg_pkg;

   // Byte offsets inside the APB window
   localparam logic [11:0] ADDR_TTMR   = 12'h000;  // Mode register
   localparam logic [11:0] ADDR_TTCR   = 12'h004;  // Count register
   localparam logic [11:0] ADDR_PRESC  = 12'h008;  // Prescaler reload
   localparam logic [11:0] ADDR_STATUS = 12'h00C;  // Write-1-to-clear flags

   // Default widths, overridden from the top level
   localparam int unsigned DEF_CNT_W   = 28;  // Compare width, at most PERIOD_W
   localparam int unsigned DEF_PRESC_W = 8;   // Divider width, at most PRESC_FW

   // Field widths in the control bundle
   localparam int unsigned PERIOD_W = 28;  // Period field, below the TTMR flags
   localparam int unsigned PRESC_FW = 8;   // Prescaler field

   // Timer mode, same encoding as TTMR[31:30]
   typedef enum logic [1:0] {
      DISABLED   = 2'd0,  // No counting, no match
      RESTART    = 2'd1,  // Clear on match
      STOP       = 2'd2,  // Hold on match
      CONTINUOUS = 2'd3   // Count through match
   } tt_mode_e;

   // Live control values, fanned out to all datapath blocks
   typedef struct packed {
      tt_mode_e            mode;    // Timer mode
      logic                ie;      // Interrupt enable
      logic [PERIOD_W-1:0] period;  // Match value, zero above CNT_W
      logic [PRESC_FW-1:0] presc;   // Divider reload, zero above PRESC_W
   } tt_ctrl_t;

endpackage
